// ==== test/mask_testdata.txt ====
32
000000 00
ffffff ff
ff0000 55
00ff00 55
0000ff 55
010000 00
010100 00
010101 01
102030 20
808080 80
fffe00 a9
123456 34
abcdef cd
7f7f80 7f
c0ffee e4
00007f 2a
646464 64
0a0b0c 0b
fefefe fe
800000 2a
203040 30
55aa55 71
aa55aa 8d
0f0f0f 0f
f0f0f0 f0
3c5a78 5a
998877 88
112233 22
deadbe c3
010203 02
fdfdff fd
7e8081 7f

// ==== mask_capture_top.f ====
+incdir+common
common/mask_pkg.sv
rtl/pixel_fifo.sv
rtl/grayscale_mask.sv
rtl/mask_bram.sv
rtl/axil_mask_port.sv
rtl/mask_capture_top.sv
test/mask_capture_tb.sv

// ==== test/mask_capture_tb.sv ====
/*
  Self-checking testbench for mask_capture_top. It must run from the project root to find
  test/mask_testdata.txt, and it expects one frame of MASK_WIDTH * MASK_HEIGHT pixels in it.
*/
`timescale 1ns/100ps
`include "mask_cfg.svh"

module mask_capture_tb import mask_pkg::*; ();

    localparam int CLOCK_PERIOD    = 10;
    localparam int FIFO_DEPTH      = `MASK_FIFO_DEPTH;
    localparam int WATCHDOG_CYCLES = 2 * 40 * FRAME_SIZE + 2000;
    localparam logic [1:0] OKAY    = 2'b00;
    localparam logic [1:0] SLVERR  = 2'b10;

    logic        clock;
    logic        reset;
    logic        pix_valid;
    logic        pix_ready;
    pixel_rgb_t  pix_data;
    logic [11:0] s_axil_awaddr;
    logic        s_axil_awvalid;
    logic        s_axil_awready;
    logic [31:0] s_axil_wdata;
    logic [3:0]  s_axil_wstrb;
    logic        s_axil_wvalid;
    logic        s_axil_wready;
    logic [1:0]  s_axil_bresp;
    logic        s_axil_bvalid;
    logic        s_axil_bready;
    logic [11:0] s_axil_araddr;
    logic        s_axil_arvalid;
    logic        s_axil_arready;
    logic [31:0] s_axil_rdata;
    logic [1:0]  s_axil_rresp;
    logic        s_axil_rvalid;
    logic        s_axil_rready;

    pixel_rgb_t  pixels [FRAME_SIZE];
    logic [7:0]  gray_exp [FRAME_SIZE];
    int          n_pix;
    int          stalls;
    int          checks;
    int          errors;

    mask_capture_top dut0 (.*);

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    // Floor of the channel mean, optionally of the inverted pixel
    function automatic logic [7:0] gray_of(input pixel_rgb_t p, input bit invert);
        int r;
        int g;
        int b;
        r = invert ? 255 - int'(p.r) : int'(p.r);
        g = invert ? 255 - int'(p.g) : int'(p.g);
        b = invert ? 255 - int'(p.b) : int'(p.b);
        return 8'((r + g + b) / 3);
    endfunction

    task automatic load_testdata();
        int fd;
        int code;
        int total;
        logic [23:0] rgb;
        logic [7:0] g;
        fd = $fopen("test/mask_testdata.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the test data file test/mask_testdata.txt");
        end else begin
            code = $fscanf(fd, "%d\n", total);
            if (code != 1 || total != FRAME_SIZE) begin
                errors++;
                $display("Test data header does not give a frame of %0d pixels", FRAME_SIZE);
            end
            while (n_pix < FRAME_SIZE && $fscanf(fd, "%h %h\n", rgb, g) == 2) begin
                pixels[n_pix]   = rgb;
                gray_exp[n_pix] = g;
                // The file value must agree with the averaging rule
                check_value($sformatf("testdata gray %0d", n_pix), g, gray_of(rgb, 1'b0));
                n_pix++;
            end
            $fclose(fd);
        end
    endtask

    task automatic axil_write(input logic [11:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        bit hs;
        int delay;
        @(posedge clock);
        s_axil_awaddr  <= addr;
        s_axil_awvalid <= 1'b1;
        s_axil_wdata   <= data;
        s_axil_wstrb   <= 4'hf;
        s_axil_wvalid  <= 1'b1;
        do begin
            @(negedge clock);
            hs = s_axil_awready && s_axil_wready;
            @(posedge clock);
        end while (!hs);
        s_axil_awvalid <= 1'b0;
        s_axil_wvalid  <= 1'b0;
        delay = $urandom_range(3, 0);
        repeat (delay) @(posedge clock);
        s_axil_bready <= 1'b1;
        do begin
            @(negedge clock);
            hs   = s_axil_bvalid;
            resp = s_axil_bresp;
            @(posedge clock);
        end while (!hs);
        s_axil_bready <= 1'b0;
    endtask

    task automatic axil_read(input logic [11:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        bit hs;
        int delay;
        @(posedge clock);
        s_axil_araddr  <= addr;
        s_axil_arvalid <= 1'b1;
        do begin
            @(negedge clock);
            hs = s_axil_arready;
            @(posedge clock);
        end while (!hs);
        s_axil_arvalid <= 1'b0;
        delay = $urandom_range(3, 0);
        repeat (delay) @(posedge clock);
        s_axil_rready <= 1'b1;
        do begin
            @(negedge clock);
            hs   = s_axil_rvalid;
            data = s_axil_rdata;
            resp = s_axil_rresp;
            @(posedge clock);
        end while (!hs);
        s_axil_rready <= 1'b0;
    endtask

    // Bursts longer than the FIFO keep it full, so pix_ready must drop at times
    task automatic send_frame(input bit invert);
        int i;
        int gap;
        int burst;
        bit accepted;
        pixel_rgb_t p;
        burst = 0;
        @(posedge clock);
        for (i = 0; i < n_pix; i++) begin
            if (burst == 0) begin
                gap = $urandom_range(3, 0);
                pix_valid <= 1'b0;
                repeat (gap) @(posedge clock);
                burst = $urandom_range(2 * FIFO_DEPTH, FIFO_DEPTH + 1);
            end
            p = invert ? ~pixels[i] : pixels[i];
            pix_valid <= 1'b1;
            pix_data  <= p;
            do begin
                @(negedge clock);
                accepted = pix_ready;
                if (!accepted) begin
                    stalls++;
                end
                @(posedge clock);
            end while (!accepted);
            burst--;
        end
        pix_valid <= 1'b0;
    endtask

    task automatic check_status(input string tag, input logic exp_done,
                                input logic [7:0] exp_count);
        logic [31:0] data;
        logic [1:0] resp;
        mask_rdata_u view;
        axil_read(`MASK_REG_STATUS, data, resp);
        view = data;
        check_value({tag, " status rresp"}, resp, OKAY);
        check_value({tag, " frame_done"}, view.status.frame_done, exp_done);
        check_value({tag, " frame_count"}, view.status.frame_count, exp_count);
    endtask

    task automatic wait_frame_done();
        logic [31:0] data;
        logic [1:0] resp;
        mask_rdata_u view;
        do begin
            axil_read(`MASK_REG_STATUS, data, resp);
            view = data;
        end while (!view.status.frame_done);
    endtask

    task automatic check_mask(input string tag, input bit invert);
        logic [31:0] data;
        logic [1:0] resp;
        mask_rdata_u view;
        logic [7:0] expected;
        int k;
        int j;
        for (k = 0; k < WORDS; k++) begin
            axil_read(`MASK_REG_PIXEL_BASE + 12'(4 * k), data, resp);
            view = data;
            check_value($sformatf("%s mask rresp %0d", tag, k), resp, OKAY);
            for (j = 0; j < 4; j++) begin
                expected = invert ? gray_of(pixels[4 * k + j], 1'b1) : gray_exp[4 * k + j];
                check_value($sformatf("%s mask pixel %0d", tag, 4 * k + j), view.gray[j],
                            expected);
            end
        end
    endtask

    task automatic check_bad_read(input logic [11:0] addr);
        logic [31:0] data;
        logic [1:0] resp;
        axil_read(addr, data, resp);
        check_value($sformatf("rresp at 0x%0h", addr), resp, SLVERR);
        check_value($sformatf("rdata at 0x%0h", addr), data, 32'h0);
    endtask

    initial begin
        logic [1:0] resp;
        void'($urandom(32'hf935_144b));
        clock          = 1'b0;
        reset          = 1'b1;
        pix_valid      = 1'b0;
        pix_data       = '0;
        s_axil_awaddr  = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata   = '0;
        s_axil_wstrb   = '0;
        s_axil_wvalid  = 1'b0;
        s_axil_bready  = 1'b0;
        s_axil_araddr  = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready  = 1'b0;
        n_pix          = 0;
        stalls         = 0;
        checks         = 0;
        errors         = 0;
        load_testdata();
        repeat (16) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_value("pix_ready", pix_ready, 1'b1);
        check_value("s_axil_bvalid", s_axil_bvalid, 1'b0);
        check_value("s_axil_rvalid", s_axil_rvalid, 1'b0);

        if (n_pix == FRAME_SIZE) begin
            check_status("reset", 1'b0, 8'd0);

            // First frame under back-pressure
            send_frame(1'b0);
            if (stalls == 0) begin
                errors++;
                $display("The pixel stream never saw pix_ready low during the burst");
            end
            wait_frame_done();
            check_status("frame 1", 1'b1, 8'd1);
            check_mask("frame 1", 1'b0);

            // Writes away from the status register must change nothing
            axil_write(12'h004, 32'h1, resp);
            check_value("bresp at 0x4", resp, SLVERR);
            axil_write(`MASK_REG_PIXEL_BASE + 12'h4, 32'hffff_ffff, resp);
            check_value("bresp at 0x104", resp, SLVERR);
            check_status("bad write", 1'b1, 8'd1);
            check_mask("bad write", 1'b0);

            axil_write(`MASK_REG_STATUS, 32'h1, resp);
            check_value("bresp of clear", resp, OKAY);
            check_status("clear", 1'b0, 8'd1);

            check_bad_read(12'h004);
            check_bad_read(`MASK_REG_PIXEL_BASE + 12'(FRAME_SIZE));
            check_bad_read(12'hffc);

            // Second frame with inverted channels lands at the same addresses
            send_frame(1'b1);
            wait_frame_done();
            check_status("frame 2", 1'b1, 8'd2);
            check_mask("frame 2", 1'b1);
        end else begin
            errors++;
            $display("Test data holds %0d pixels instead of %0d", n_pix, FRAME_SIZE);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("Checks: %0d, errors: %0d", checks, errors + 1);
        $display("Test FAILED");
        $finish;
    end

endmodule

// ==== rtl/mask_capture_top.sv ====
/*
  Grayscale mask capture: RGB stream in, mask and status out over AXI4-Lite.
  The input stream is stalled with pix_ready while the pixel FIFO is full.
*/
`timescale 1ns/100ps

module mask_capture_top import mask_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic        pix_valid,
    output logic        pix_ready,
    input  pixel_rgb_t  pix_data,
    input  logic [11:0] s_axil_awaddr,
    input  logic        s_axil_awvalid,
    output logic        s_axil_awready,
    input  logic [31:0] s_axil_wdata,
    input  logic [3:0]  s_axil_wstrb,
    input  logic        s_axil_wvalid,
    output logic        s_axil_wready,
    output logic [1:0]  s_axil_bresp,
    output logic        s_axil_bvalid,
    input  logic        s_axil_bready,
    input  logic [11:0] s_axil_araddr,
    input  logic        s_axil_arvalid,
    output logic        s_axil_arready,
    output logic [31:0] s_axil_rdata,
    output logic [1:0]  s_axil_rresp,
    output logic        s_axil_rvalid,
    input  logic        s_axil_rready
);

    logic              fifo_full;
    logic              fifo_empty;
    logic              fifo_rd_en;
    pixel_rgb_t        fifo_dout;
    mask_wr_t          mask_wr;
    logic              frame_done;
    logic [WORD_W-1:0] rd_word;
    logic [31:0]       rd_data;

    assign pix_ready = !fifo_full;

    pixel_fifo fifo0 (
        .clock (clock),
        .reset (reset),
        .wr_en (pix_valid),
        .din   (pix_data),
        .full  (fifo_full),
        .rd_en (fifo_rd_en),
        .dout  (fifo_dout),
        .empty (fifo_empty)
    );

    grayscale_mask gray0 (
        .clock      (clock),
        .reset      (reset),
        .in_rd_en   (fifo_rd_en),
        .in_empty   (fifo_empty),
        .in_dout    (fifo_dout),
        .mask_wr    (mask_wr),
        .frame_done (frame_done)
    );

    mask_bram bram0 (
        .clock   (clock),
        .wr      (mask_wr),
        .rd_word (rd_word),
        .rd_data (rd_data)
    );

    axil_mask_port axil0 (
        .clock          (clock),
        .reset          (reset),
        .frame_done     (frame_done),
        .rd_word        (rd_word),
        .rd_data        (rd_data),
        .s_axil_awaddr  (s_axil_awaddr),
        .s_axil_awvalid (s_axil_awvalid),
        .s_axil_awready (s_axil_awready),
        .s_axil_wdata   (s_axil_wdata),
        .s_axil_wstrb   (s_axil_wstrb),
        .s_axil_wvalid  (s_axil_wvalid),
        .s_axil_wready  (s_axil_wready),
        .s_axil_bresp   (s_axil_bresp),
        .s_axil_bvalid  (s_axil_bvalid),
        .s_axil_bready  (s_axil_bready),
        .s_axil_araddr  (s_axil_araddr),
        .s_axil_arvalid (s_axil_arvalid),
        .s_axil_arready (s_axil_arready),
        .s_axil_rdata   (s_axil_rdata),
        .s_axil_rresp   (s_axil_rresp),
        .s_axil_rvalid  (s_axil_rvalid),
        .s_axil_rready  (s_axil_rready)
    );

endmodule

// ==== rtl/axil_mask_port.sv ====
/*
  AXI4-Lite slave with one transaction in flight per direction. Status at
  MASK_REG_STATUS, read-only mask words from MASK_REG_PIXEL_BASE. Other addresses give SLVERR.
*/
`timescale 1ns/100ps
`include "mask_cfg.svh"

module axil_mask_port import mask_pkg::*; (
    input  logic              clock,
    input  logic              reset,
    input  logic              frame_done,
    output logic [WORD_W-1:0] rd_word,
    input  logic [31:0]       rd_data,
    input  logic [11:0]       s_axil_awaddr,
    input  logic              s_axil_awvalid,
    output logic              s_axil_awready,
    input  logic [31:0]       s_axil_wdata,
    input  logic [3:0]        s_axil_wstrb,
    input  logic              s_axil_wvalid,
    output logic              s_axil_wready,
    output logic [1:0]        s_axil_bresp,
    output logic              s_axil_bvalid,
    input  logic              s_axil_bready,
    input  logic [11:0]       s_axil_araddr,
    input  logic              s_axil_arvalid,
    output logic              s_axil_arready,
    output logic [31:0]       s_axil_rdata,
    output logic [1:0]        s_axil_rresp,
    output logic              s_axil_rvalid,
    input  logic              s_axil_rready
);

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic       done;
    logic [7:0] count;
    logic       wr_hs;
    logic       wr_status;
    logic       clear;
    logic [11:0] ar_addr;
    logic [11:0] ar_off;
    logic       ar_pend;
    logic       rd_pend;
    logic       rd_status;
    logic       rd_window;
    mask_rdata_u rd_view;

    // Write channel takes address and data in the same cycle
    assign wr_hs          = s_axil_awvalid && s_axil_wvalid && !s_axil_bvalid;
    assign s_axil_awready = wr_hs;
    assign s_axil_wready  = wr_hs;
    assign wr_status      = (s_axil_awaddr == `MASK_REG_STATUS);
    assign clear          = wr_hs && wr_status && s_axil_wstrb[0] && s_axil_wdata[0];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            s_axil_bvalid <= 1'b0;
        end else if (wr_hs) begin
            s_axil_bvalid <= 1'b1;
        end else if (s_axil_bready) begin
            s_axil_bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (wr_hs) begin
            s_axil_bresp <= wr_status ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // A new frame wins over a clear in the same cycle
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            done  <= 1'b0;
            count <= '0;
        end else if (frame_done) begin
            done  <= 1'b1;
            count <= count + 1'b1;
        end else if (clear) begin
            done <= 1'b0;
        end
    end

    // A read latches the address and then waits one cycle for the BRAM
    assign s_axil_arready = !(ar_pend || rd_pend || s_axil_rvalid);
    assign ar_off    = ar_addr - `MASK_REG_PIXEL_BASE;
    assign rd_word   = ar_off[WORD_W+1:2];
    assign rd_status = (ar_addr == `MASK_REG_STATUS);
    assign rd_window = (ar_addr >= `MASK_REG_PIXEL_BASE) && (ar_off < 12'(FRAME_SIZE));

    always_comb begin
        rd_view = '0;
        if (rd_status) begin
            rd_view.status.frame_done  = done;
            rd_view.status.frame_count = count;
        end else if (rd_window) begin
            rd_view.gray = rd_data;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            ar_pend       <= 1'b0;
            rd_pend       <= 1'b0;
            s_axil_rvalid <= 1'b0;
        end else begin
            ar_pend <= s_axil_arvalid && s_axil_arready;
            rd_pend <= ar_pend;
            if (rd_pend) begin
                s_axil_rvalid <= 1'b1;
            end else if (s_axil_rready) begin
                s_axil_rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (s_axil_arvalid && s_axil_arready) begin
            ar_addr <= s_axil_araddr;
        end
        if (rd_pend) begin
            s_axil_rdata <= rd_view;
            s_axil_rresp <= (rd_status || rd_window) ? RESP_OKAY : RESP_SLVERR;
        end
    end

endmodule

// ==== rtl/mask_bram.sv ====
/*
  One gray byte per pixel, stored as 32-bit words with byte lanes.
  Byte writes, word reads with one cycle of latency. No reset on the contents.
*/
`timescale 1ns/100ps

module mask_bram import mask_pkg::*; (
    input  logic              clock,
    input  mask_wr_t          wr,
    input  logic [WORD_W-1:0] rd_word,
    output logic [31:0]       rd_data
);

    // Pixel 4k sits in lane 0 of word k
    logic [3:0][7:0] mem [WORDS];

    always_ff @(posedge clock) begin
        if (wr.en) begin
            mem[wr.addr[ADDR_W-1:2]][wr.addr[1:0]] <= wr.data;
        end
    end

    always_ff @(posedge clock) begin
        rd_data <= mem[rd_word];
    end

endmodule

// ==== rtl/grayscale_mask.sv ====
/*
  Averages R, G and B of each pixel and writes the gray byte to the mask memory in
  raster order. A frame is exactly MASK_WIDTH * MASK_HEIGHT pixels with no sync signals.
*/
`timescale 1ns/100ps
`include "mask_cfg.svh"

module grayscale_mask import mask_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    output logic       in_rd_en,
    input  logic       in_empty,
    input  pixel_rgb_t in_dout,
    output mask_wr_t   mask_wr,
    output logic       frame_done
);

    localparam int X_W = $clog2(`MASK_WIDTH);
    localparam int Y_W = $clog2(`MASK_HEIGHT);

    typedef enum logic [1:0] {IDLE, GRAYSCALE, OUTPUT} state_t;

    state_t state;
    state_t next_state;
    logic [7:0] gray;
    logic [7:0] gray_c;
    logic [X_W-1:0] x;
    logic [X_W-1:0] x_c;
    logic [Y_W-1:0] y;
    logic [Y_W-1:0] y_c;
    logic [9:0] sum;

    // Ten bits hold the largest sum of three channels
    assign sum = {2'b00, in_dout.r} + {2'b00, in_dout.g} + {2'b00, in_dout.b};

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= IDLE;
            x     <= '0;
            y     <= '0;
        end else begin
            state <= next_state;
            x     <= x_c;
            y     <= y_c;
        end
    end

    always_ff @(posedge clock) begin
        gray <= gray_c;
    end

    always_comb begin
        next_state = state;
        gray_c     = gray;
        x_c        = x;
        y_c        = y;
        in_rd_en   = 1'b0;
        mask_wr    = '0;
        frame_done = 1'b0;

        case (state)
            IDLE: begin
                // A new frame starts at the top left corner
                if (!in_empty) begin
                    next_state = GRAYSCALE;
                    x_c        = '0;
                    y_c        = '0;
                end
            end

            GRAYSCALE: begin
                if (!in_empty) begin
                    gray_c     = 8'(sum / 10'd3);
                    in_rd_en   = 1'b1;
                    next_state = OUTPUT;
                end
            end

            OUTPUT: begin
                mask_wr.en   = 1'b1;
                mask_wr.addr = ADDR_W'(y) * ADDR_W'(`MASK_WIDTH) + ADDR_W'(x);
                mask_wr.data = gray;
                next_state   = GRAYSCALE;
                if (x == X_W'(`MASK_WIDTH - 1)) begin
                    x_c = '0;
                    if (y == Y_W'(`MASK_HEIGHT - 1)) begin
                        // Last pixel of the frame
                        frame_done = 1'b1;
                        next_state = IDLE;
                    end else begin
                        y_c = y + 1'b1;
                    end
                end else begin
                    x_c = x + 1'b1;
                end
            end

            default: begin
                next_state = IDLE;
            end
        endcase
    end

endmodule

// ==== rtl/pixel_fifo.sv ====
/*
  First-word-fall-through FIFO for RGB pixels. A push while full and a pop while
  empty are dropped silently, so the producer must watch full.
*/
`timescale 1ns/100ps
`include "mask_cfg.svh"

module pixel_fifo import mask_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       wr_en,
    input  pixel_rgb_t din,
    output logic       full,
    input  logic       rd_en,
    output pixel_rgb_t dout,
    output logic       empty
);

    localparam int DEPTH = `MASK_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    pixel_rgb_t mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic push;
    logic pop;

    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);
    assign push  = wr_en && !full;
    assign pop   = rd_en && !empty;

    // The head entry is always on the output
    assign dout = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== common/mask_pkg.sv ====
/*
  Shared types of the mask capture subsystem. The widths are derived from mask_cfg.svh.
*/
`include "mask_cfg.svh"

package mask_pkg;

    localparam int FRAME_SIZE = `MASK_WIDTH * `MASK_HEIGHT;
    localparam int ADDR_W     = $clog2(FRAME_SIZE);
    localparam int WORDS      = FRAME_SIZE / 4;
    localparam int WORD_W     = $clog2(WORDS);

    // One RGB pixel with red in the top byte
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } pixel_rgb_t;

    // Byte write port of the mask memory
    typedef struct packed {
        logic              en;
        logic [ADDR_W-1:0] addr;
        logic [7:0]        data;
    } mask_wr_t;

    // Layout of the status register
    typedef struct packed {
        logic [15:0] rsvd_hi;
        logic [7:0]  frame_count;
        logic [6:0]  rsvd_lo;
        logic        frame_done;
    } mask_status_t;

    // A host read word is either the status register or four gray bytes
    typedef union packed {
        mask_status_t      status;
        logic [3:0][7:0]   gray;
    } mask_rdata_u;

endpackage

// ==== common/mask_cfg.svh ====
/*
  Frame geometry, FIFO depth and AXI4-Lite register map of the mask capture block.
  The frame size must be a multiple of 4, because the mask is read as whole 32-bit words.
*/
`ifndef MASK_CFG_SVH
`define MASK_CFG_SVH

// Image size in pixels
`define MASK_WIDTH          8
`define MASK_HEIGHT         4

// Number of RGB pixels buffered ahead of the grayscale stage
`define MASK_FIFO_DEPTH     4

// Byte addresses on the 12-bit AXI4-Lite port
`define MASK_REG_STATUS     12'h000
`define MASK_REG_PIXEL_BASE 12'h100

`endif
